//--- snowball_params.svh
`ifndef SNOWBALL_PARAMS_SVH
`define SNOWBALL_PARAMS_SVH

// Cache line index, taken from address bits 7:0
`define SNOWBALL_IDX_W 8

// Translation table index, taken from address bits 15:8
`define SNOWBALL_TLB_IDX_W 8

// Entries in each request or fill queue
`define SNOWBALL_FIFO_DEPTH 4

`endif

//--- cache_pkg.sv
`include "snowball_params.svh"

package cache_pkg;

  // ----------------------------------------------------------------------
  // Virtual address fields as the CPU presents them
  // ----------------------------------------------------------------------
  typedef logic [`SNOWBALL_IDX_W-1:0]     cache_idx_t;  // Bits 7:0
  typedef logic [`SNOWBALL_TLB_IDX_W-1:0] tlb_idx_t;    // Bits 15:8
  typedef logic [15:0]                    vtag_t;       // Bits 31:16

  // What a cache line remembers about its address
  typedef struct packed {
    vtag_t    page;  // Physical page tag
    tlb_idx_t tidx;  // Middle address bits
  } line_tag_t;

  // ----------------------------------------------------------------------
  // One posted operation towards the outside bus
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [31:0] addr;   // Physical, after translation
    logic [31:0] wdata;  // Unused for reads
    logic        write;
  } bus_req_t;

endpackage

//--- bus_pkg.sv
`include "snowball_params.svh"

package bus_pkg;

  // ----------------------------------------------------------------------
  // Target decode on address bits 31:30
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    REGION_MEM = 2'b00,  // Also stands for 2'b01 and 2'b10
    REGION_DMA = 2'b11
  } region_t;

  function automatic region_t region_of(input logic [1:0] top_bits);
    if (top_bits == 2'b11)
      return REGION_DMA;
    return REGION_MEM;
  endfunction

  // ----------------------------------------------------------------------
  // Read data coming back to the cache
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [31:0]                data;  // Word to install and return
    logic [`SNOWBALL_IDX_W-1:0] idx;   // Line it belongs to
  } fill_rsp_t;

endpackage

//--- req_fifo.sv
`timescale 1ns/1ns
`include "snowball_params.svh"

module req_fifo #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     CPU_CLK,
  input  logic     RST,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     full,
  output logic     empty
);

  localparam int DEPTH = `SNOWBALL_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  payload_t         slots [DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_push, do_pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign head    = slots[rd_ptr];  // Fall-through head
  assign full    = (count == (PTR_W + 1)'(DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge CPU_CLK)
  begin
    if (RST)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_inc(rd_ptr);
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (do_push)
      slots[wr_ptr] <= push_data;
  end

  a_no_underflow: assert property (@(posedge CPU_CLK) disable iff (RST) !(pop && empty));
  a_no_overflow:  assert property (@(posedge CPU_CLK) disable iff (RST) !(push && full));

endmodule

//--- cache_lookup.sv
`timescale 1ns/1ns
`include "snowball_params.svh"

module cache_lookup
  import cache_pkg::*;
  import bus_pkg::*;
(
  input  logic        CPU_CLK,
  input  logic        RST,
  input  logic        cpu_req,
  input  logic [31:0] cpu_addr,
  input  logic [31:0] cpu_wdata,
  input  logic        cpu_we,
  input  logic        cpu_force_miss,
  input  logic        tlb_we,
  input  logic        vmem_act,
  input  logic        req_full,
  input  logic        fill_empty,
  input  fill_rsp_t   fill_data,
  output logic [31:0] cpu_rdata,
  output logic        cpu_done,
  output logic        cache_busy,
  output logic        mmu_fault,
  output logic        req_push,
  output bus_req_t    req_data,
  output logic        fill_pop
);

  localparam int LINES       = 1 << `SNOWBALL_IDX_W;
  localparam int TLB_ENTRIES = 1 << `SNOWBALL_TLB_IDX_W;

  logic [31:0]      data_mem [LINES];
  line_tag_t        tag_mem  [LINES];
  logic [LINES-1:0] line_vld;
  vtag_t            tlb_ptag [TLB_ENTRIES];
  vtag_t            tlb_vtag [TLB_ENTRIES];

  logic        cache_acc, tlb_acc;
  cache_idx_t  s0_idx;
  tlb_idx_t    s0_tidx;

  // Compare stage
  logic        s1_vld;
  logic [31:0] s1_addr, s1_wdata;
  logic        s1_we, s1_force, s1_vmem;
  logic [31:0] rd_data;
  line_tag_t   rd_tag;
  logic        rd_vld;
  vtag_t       rd_ptag, rd_vtag;
  cache_idx_t  s1_idx;
  tlb_idx_t    s1_tidx;
  vtag_t       s1_vtag, phys_tag;
  line_tag_t   cmp_tag;
  logic        fault, hit, need_bus, issue;
  logic        s1_fault, s1_hit, wr_issue, rd_issue;

  // Outstanding read miss
  logic        miss_wait;
  line_tag_t   miss_tag;

  // Shared write port of the line arrays
  logic        ram_we;
  cache_idx_t  ram_idx;
  logic [31:0] ram_word;
  line_tag_t   ram_tag;

  // ----------------------------------------------------------------------
  // Request acceptance
  // ----------------------------------------------------------------------
  assign cache_busy = s1_vld | miss_wait | cpu_done;  // One request at a time
  assign cache_acc  = cpu_req && !cache_busy && !tlb_we;
  assign tlb_acc    = cpu_req && !cache_busy && tlb_we;
  assign s0_idx     = cpu_addr[`SNOWBALL_IDX_W-1:0];
  assign s0_tidx    = cpu_addr[8 +: `SNOWBALL_TLB_IDX_W];

  // ----------------------------------------------------------------------
  // Translation, hit and fault decision
  // ----------------------------------------------------------------------
  assign s1_idx   = s1_addr[`SNOWBALL_IDX_W-1:0];
  assign s1_tidx  = s1_addr[8 +: `SNOWBALL_TLB_IDX_W];
  assign s1_vtag  = s1_addr[31:16];
  assign phys_tag = s1_vmem ? rd_ptag : s1_vtag;
  assign fault    = s1_vmem && (rd_vtag != s1_vtag);
  assign cmp_tag  = '{page: phys_tag, tidx: s1_tidx};
  assign hit      = rd_vld && (rd_tag == cmp_tag) && !s1_force;
  assign need_bus = s1_we || !hit;

  assign s1_fault = s1_vld && fault;
  assign s1_hit   = s1_vld && !fault && !need_bus;
  assign issue    = s1_vld && !fault && need_bus && !req_full;  // Held while full
  assign wr_issue = issue && s1_we;
  assign rd_issue = issue && !s1_we;
  assign fill_pop = miss_wait && !fill_empty;

  assign ram_we   = wr_issue | fill_pop;
  assign ram_idx  = fill_pop ? fill_data.idx : s1_idx;
  assign ram_word = fill_pop ? fill_data.data : s1_wdata;
  assign ram_tag  = fill_pop ? miss_tag : cmp_tag;

  always_ff @(posedge CPU_CLK)
  begin
    if (RST)
    begin
      s1_vld    <= 1'b0;
      miss_wait <= 1'b0;
      cpu_done  <= 1'b0;
      mmu_fault <= 1'b0;
      req_push  <= 1'b0;
      line_vld  <= '0;
    end
    else
    begin
      cpu_done  <= tlb_acc | s1_fault | s1_hit | wr_issue | fill_pop;
      mmu_fault <= s1_fault;
      req_push  <= issue;
      if (cache_acc)
        s1_vld <= 1'b1;
      else if (s1_fault || s1_hit || issue)
        s1_vld <= 1'b0;
      if (rd_issue)
        miss_wait <= 1'b1;
      else if (fill_pop)
        miss_wait <= 1'b0;
      if (ram_we)
        line_vld[ram_idx] <= 1'b1;
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (cache_acc)
    begin
      s1_addr  <= cpu_addr;
      s1_wdata <= cpu_wdata;
      s1_we    <= cpu_we;
      s1_force <= cpu_force_miss;
      s1_vmem  <= vmem_act;
      rd_data  <= data_mem[s0_idx];  // Array read stage
      rd_tag   <= tag_mem[s0_idx];
      rd_vld   <= line_vld[s0_idx];
      rd_ptag  <= tlb_ptag[s0_tidx];
      rd_vtag  <= tlb_vtag[s0_tidx];
    end
    if (tlb_acc)
    begin
      tlb_ptag[s0_tidx] <= cpu_wdata[31:16];
      tlb_vtag[s0_tidx] <= cpu_wdata[15:0];
    end
    if (ram_we)
    begin
      data_mem[ram_idx] <= ram_word;
      tag_mem[ram_idx]  <= ram_tag;
    end
    if (issue)
      req_data <= '{addr: {phys_tag, s1_addr[15:0]}, wdata: s1_wdata, write: s1_we};
    if (rd_issue)
      miss_tag <= cmp_tag;
    if (s1_hit)
      cpu_rdata <= rd_data;
    else if (fill_pop)
      cpu_rdata <= fill_data.data;  // Finishes the waiting read
  end

  // Registered push was decided against a queue that had room
  a_push_room: assert property (@(posedge CPU_CLK) disable iff (RST)
    req_push |-> !req_full);

  a_done_pulse: assert property (@(posedge CPU_CLK) disable iff (RST)
    cpu_done |=> !cpu_done);

endmodule

//--- mem_sequencer.sv
`timescale 1ns/1ns
`include "snowball_params.svh"

module mem_sequencer
  import cache_pkg::*;
  import bus_pkg::*;
(
  input  logic        CPU_CLK,
  input  logic        RST,
  input  logic        req_empty,
  input  bus_req_t    req_head,
  input  logic        fill_full,
  input  logic        mem_ack,
  input  logic [31:0] mem_rdata,
  input  logic        dma_wrte_ack,
  input  logic        dma_read_ack,
  input  logic [31:0] dma_rdata,
  output logic        req_pop,
  output logic        fill_push,
  output fill_rsp_t   fill_data,
  output logic        mem_do_act,
  output logic [31:0] mem_addr,
  output logic        mem_we,
  output logic [31:0] mem_wdata,
  output logic        dma_wrte,
  output logic        dma_read
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,     // Head taken, level raised at the end of this cycle
    ST_WAIT_ACK,
    ST_FILL       // Read data waiting for room in the fill queue
  } seq_state_t;

  seq_state_t  state;
  region_t     head_region;
  logic        ack_seen;
  logic [31:0] rsp_word;

  assign head_region = region_of(req_head.addr[31:30]);
  assign req_pop     = (state == ST_ISSUE);
  assign fill_push   = (state == ST_FILL) && !fill_full;
  assign ack_seen    = (mem_do_act && mem_ack) ||
                       (dma_wrte && dma_wrte_ack) ||
                       (dma_read && dma_read_ack);
  assign rsp_word    = dma_read ? dma_rdata : mem_rdata;

  // ----------------------------------------------------------------------
  // Sequencer FSM and request levels
  // ----------------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (RST)
    begin
      state      <= ST_IDLE;
      mem_do_act <= 1'b0;
      dma_wrte   <= 1'b0;
      dma_read   <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
          if (!req_empty)
            state <= ST_ISSUE;
        ST_ISSUE:
        begin
          mem_do_act <= (head_region == REGION_MEM);
          dma_wrte   <= (head_region == REGION_DMA) && req_head.write;
          dma_read   <= (head_region == REGION_DMA) && !req_head.write;
          state      <= ST_WAIT_ACK;
        end
        ST_WAIT_ACK:
          if (ack_seen)
          begin
            mem_do_act <= 1'b0;  // Drops the cycle after the acknowledge
            dma_wrte   <= 1'b0;
            dma_read   <= 1'b0;
            state      <= mem_we ? ST_IDLE : ST_FILL;
          end
        ST_FILL:
          if (!fill_full)
            state <= ST_IDLE;
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // Address and data are shared by both targets
  always_ff @(posedge CPU_CLK)
  begin
    if (state == ST_ISSUE)
    begin
      mem_addr  <= req_head.addr;
      mem_we    <= req_head.write;
      mem_wdata <= req_head.wdata;
    end
    if ((state == ST_WAIT_ACK) && ack_seen && !mem_we)
    begin
      fill_data.data <= rsp_word;
      fill_data.idx  <= mem_addr[`SNOWBALL_IDX_W-1:0];
    end
  end

  a_mem_hold: assert property (@(posedge CPU_CLK) disable iff (RST)
    mem_do_act && !mem_ack |=> mem_do_act);

endmodule

//--- snowball_top.sv
`timescale 1ns/1ns

module snowball_top
  import cache_pkg::*;
  import bus_pkg::*;
(
  input  logic        CPU_CLK,
  input  logic        RST,
  input  logic        cpu_req,
  input  logic [31:0] cpu_addr,
  input  logic [31:0] cpu_wdata,
  input  logic        cpu_we,
  input  logic        cpu_force_miss,
  input  logic        tlb_we,
  input  logic        vmem_act,
  output logic [31:0] cpu_rdata,
  output logic        cpu_done,
  output logic        cache_busy,
  output logic        mmu_fault,
  output logic [31:0] mem_addr,
  output logic        mem_we,
  output logic [31:0] mem_wdata,
  output logic        mem_do_act,
  input  logic        mem_ack,
  input  logic [31:0] mem_rdata,
  output logic        dma_wrte,
  output logic        dma_read,
  input  logic        dma_wrte_ack,
  input  logic        dma_read_ack,
  input  logic [31:0] dma_rdata
);

  logic      req_push, req_pop, req_full, req_empty;
  bus_req_t  req_data, req_head;
  logic      fill_push, fill_pop, fill_full, fill_empty;
  fill_rsp_t fill_in, fill_head;

  cache_lookup u_lookup (
    .CPU_CLK(CPU_CLK), .RST(RST),
    .cpu_req(cpu_req), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
    .cpu_we(cpu_we), .cpu_force_miss(cpu_force_miss), .tlb_we(tlb_we),
    .vmem_act(vmem_act), .req_full(req_full), .fill_empty(fill_empty),
    .fill_data(fill_head), .cpu_rdata(cpu_rdata), .cpu_done(cpu_done),
    .cache_busy(cache_busy), .mmu_fault(mmu_fault), .req_push(req_push),
    .req_data(req_data), .fill_pop(fill_pop)
  );

  // CPU to bus direction
  req_fifo #(.payload_t(bus_req_t)) u_req_q (
    .CPU_CLK(CPU_CLK), .RST(RST), .push(req_push), .push_data(req_data),
    .pop(req_pop), .head(req_head), .full(req_full), .empty(req_empty)
  );

  // Bus to CPU direction
  req_fifo #(.payload_t(fill_rsp_t)) u_fill_q (
    .CPU_CLK(CPU_CLK), .RST(RST), .push(fill_push), .push_data(fill_in),
    .pop(fill_pop), .head(fill_head), .full(fill_full), .empty(fill_empty)
  );

  mem_sequencer u_seq (
    .CPU_CLK(CPU_CLK), .RST(RST),
    .req_empty(req_empty), .req_head(req_head), .fill_full(fill_full),
    .mem_ack(mem_ack), .mem_rdata(mem_rdata), .dma_wrte_ack(dma_wrte_ack),
    .dma_read_ack(dma_read_ack), .dma_rdata(dma_rdata), .req_pop(req_pop),
    .fill_push(fill_push), .fill_data(fill_in), .mem_do_act(mem_do_act),
    .mem_addr(mem_addr), .mem_we(mem_we), .mem_wdata(mem_wdata),
    .dma_wrte(dma_wrte), .dma_read(dma_read)
  );

endmodule

//--- snowball_tb.sv
`timescale 1ns/1ns

module snowball_tb;

  localparam int TIMEOUT = 200;  // Cycles per wait

  logic        CPU_CLK;
  logic        RST;
  logic        cpu_req;
  logic [31:0] cpu_addr;
  logic [31:0] cpu_wdata;
  logic        cpu_we;
  logic        cpu_force_miss;
  logic        tlb_we;
  logic        vmem_act;
  logic [31:0] cpu_rdata;
  logic        cpu_done;
  logic        cache_busy;
  logic        mmu_fault;
  logic [31:0] mem_addr;
  logic        mem_we;
  logic [31:0] mem_wdata;
  logic        mem_do_act;
  logic        mem_ack;
  logic [31:0] mem_rdata;
  logic        dma_wrte;
  logic        dma_read;
  logic        dma_wrte_ack;
  logic        dma_read_ack;
  logic [31:0] dma_rdata;

  integer      seed = 32'h143c_22eb;
  int          checks, mismatches, other_failures;
  bit          timed_out;
  bit          ack_hold;        // Bus model withholds acknowledges
  int          bus_cnt, mem_cnt, rd_cnt;
  logic [31:0] last_rd_addr;
  logic [31:0] mem_model [logic [31:0]];
  logic [31:0] tlb_model [logic [7:0]];  // {ptag, vtag} per entry
  logic [31:0] exp_wr_addr [$];          // Posted writes in issue order
  logic [31:0] exp_wr_data [$];

  snowball_top i_snowball_top (.*);

  initial
  begin
    CPU_CLK = 1'b0;
    forever #50 CPU_CLK = ~CPU_CLK;
  end

  // ----------------------------------------------------------------------
  // Checks and waits
  // ----------------------------------------------------------------------
  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      mismatches++;
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input bit ok, input string what);
    assert (ok)
    else
    begin
      other_failures++;
      timed_out = 1'b1;
      $display("timeout at %0t ns: no %s within %0d cycles", $time, what, TIMEOUT);
    end
  endtask

  task automatic wait_for_done(output int lat);
    lat = 0;
    while (!cpu_done && lat < TIMEOUT)
    begin
      @(negedge CPU_CLK);
      cpu_req = 1'b0;  // Strobe lasts one cycle
      lat++;
    end
    report_timeout(cpu_done, "cpu_done");
  endtask

  task automatic wait_until_idle();
    int n;
    n = 0;
    while (cache_busy && n < TIMEOUT)
    begin
      @(negedge CPU_CLK);
      n++;
    end
    report_timeout(!cache_busy, "drop of cache_busy");
  endtask

  task automatic wait_for_drain();
    int n;
    n = 0;
    while (exp_wr_addr.size() != 0 && n < TIMEOUT)
    begin
      @(negedge CPU_CLK);
      n++;
    end
    report_timeout(exp_wr_addr.size() == 0, "end of the posted writes");
  endtask

  // Unwritten words read back as the inverse of their address
  function automatic logic [31:0] stored_word(input logic [31:0] addr);
    if (mem_model.exists(addr))
      return mem_model[addr];
    return ~addr;
  endfunction

  task automatic take_write(input logic [31:0] addr, input logic [31:0] data);
    mem_model[addr] = data;
    assert (exp_wr_addr.size() != 0)
    else
    begin
      other_failures++;
      $display("bus write to %h at %0t ns that no request asked for", addr, $time);
    end
    if (exp_wr_addr.size() != 0)
    begin
      check_word("bus write address", addr, exp_wr_addr.pop_front());
      check_word("bus write data", data, exp_wr_data.pop_front());
    end
  endtask

  // ----------------------------------------------------------------------
  // Reads take the data column as their expected bus address
  // ----------------------------------------------------------------------
  task automatic run_op(input logic [31:0] op, addr, data, vm, fm, exp_data, exp_fault);
    int          lat;
    int          rd_before, bus_before, mem_before;
    logic [31:0] phys;
    rd_before  = rd_cnt;
    bus_before = bus_cnt;
    mem_before = mem_cnt;
    if (op == 6)
    begin
      ack_hold = addr[0];
      return;
    end
    if (op == 5)
    begin
      wait_for_drain();
      if (!timed_out)
        check_word("memory word", stored_word(addr), exp_data);
      return;
    end
    wait_until_idle();
    if (timed_out)
      return;
    cpu_req        = 1'b1;
    cpu_addr       = addr;
    cpu_wdata      = data;
    cpu_we         = (op == 1);
    cpu_force_miss = fm[0];
    tlb_we         = (op == 0);
    vmem_act       = vm[0];
    if (op == 0)
      tlb_model[addr[15:8]] = data;
    if (op == 1)
    begin
      phys = vm[0] ? {tlb_model[addr[15:8]][31:16], addr[15:0]} : addr;
      exp_wr_addr.push_back(phys);
      exp_wr_data.push_back(data);
    end
    if (op == 1 && exp_data[0])
    begin
      repeat (4)  // Full request queue holds the write
      begin
        @(negedge CPU_CLK);
        cpu_req = 1'b0;
        check_word("cpu_done of a stalled write", cpu_done, 0);
      end
      check_word("cache_busy with a full queue", cache_busy, 1);
      ack_hold = 1'b0;
    end
    wait_for_done(lat);
    if (timed_out)
      return;
    if (op == 0)
      check_word("table write latency", lat, 1);
    if (op == 1 && !exp_data[0])
      check_word("write latency", lat, 2);
    if (op >= 2)
    begin
      check_word("read data", cpu_rdata, exp_data);
      check_word("fault flag", mmu_fault, exp_fault);
    end
    if (op == 2)
    begin
      check_word("hit latency", lat, 2);
      wait_until_idle();  // A stray miss keeps the cache busy until its fill
      check_word("bus reads on a hit", rd_cnt, rd_before);
    end
    if (op == 3)
    begin
      check_word("bus reads on a miss", rd_cnt, rd_before + 1);
      check_word("bus read address", last_rd_addr, data);
      check_word("writes still posted", exp_wr_addr.size(), 0);
      if (data[31:30] == 2'b11)
        check_word("memory port use on a DMA read", mem_cnt, mem_before);
    end
    if (op == 4)
    begin
      check_word("fault latency", lat, 2);
      wait_until_idle();
      check_word("bus accesses on a fault", bus_cnt, bus_before);
    end
  endtask

  // ----------------------------------------------------------------------
  // Bus model for the memory and DMA ports
  // ----------------------------------------------------------------------
  initial
  begin : bus_model
    int unsigned delay;
    int          held;
    mem_ack      = 1'b0;
    mem_rdata    = '0;
    dma_wrte_ack = 1'b0;
    dma_read_ack = 1'b0;
    dma_rdata    = '0;
    forever
    begin
      @(negedge CPU_CLK);
      if (mem_do_act || dma_wrte || dma_read)
      begin
        delay = $unsigned($random(seed)) % 4;  // 0 to 3 cycles
        repeat (delay) @(negedge CPU_CLK);
        held = 0;
        while (ack_hold && held < TIMEOUT)
        begin
          @(negedge CPU_CLK);
          held++;
        end
        report_timeout(!ack_hold, "release of the held acknowledge");
        ack_hold = 1'b0;
        bus_cnt++;
        if (mem_do_act)
        begin
          mem_cnt++;
          if (mem_we)
            take_write(mem_addr, mem_wdata);
          else
          begin
            rd_cnt++;
            last_rd_addr = mem_addr;
            mem_rdata    = stored_word(mem_addr);
          end
          mem_ack = 1'b1;
        end
        else if (dma_wrte)
        begin
          take_write(mem_addr, mem_wdata);
          dma_wrte_ack = 1'b1;
        end
        else
        begin
          rd_cnt++;
          last_rd_addr = mem_addr;
          dma_rdata    = mem_addr + 1;
          dma_read_ack = 1'b1;
        end
        @(negedge CPU_CLK);
        mem_ack      = 1'b0;
        dma_wrte_ack = 1'b0;
        dma_read_ack = 1'b0;
        check_word("request level after acknowledge", {mem_do_act, dma_wrte, dma_read}, 0);
      end
    end
  end

  initial
  begin : main
    int               fd;
    int               n;
    logic [8*128-1:0] line_buf;
    logic [31:0]      f_op, f_addr, f_data, f_vm, f_fm, f_exp, f_flt;
    RST            = 1'b1;
    cpu_req        = 1'b0;
    cpu_addr       = '0;
    cpu_wdata      = '0;
    cpu_we         = 1'b0;
    cpu_force_miss = 1'b0;
    tlb_we         = 1'b0;
    vmem_act       = 1'b0;
    repeat (5) @(negedge CPU_CLK);
    RST = 1'b0;
    fd = $fopen("snowball_stimulus.txt", "r");
    assert (fd != 0)
    else
    begin
      other_failures++;
      $display("could not open snowball_stimulus.txt");
    end
    while (fd != 0 && !timed_out && !$feof(fd))
    begin
      line_buf = '0;
      if ($fgets(line_buf, fd) != 0)
      begin
        n = $sscanf(line_buf, "%h %h %h %h %h %h %h",
                    f_op, f_addr, f_data, f_vm, f_fm, f_exp, f_flt);
        if (n == 7)  // Comment lines do not scan
          run_op(f_op, f_addr, f_data, f_vm, f_fm, f_exp, f_flt);
      end
    end
    if (fd != 0)
      $fclose(fd);
    $display("checks %0d, mismatches %0d, other failures %0d",
             checks, mismatches, other_failures);
    if (mismatches == 0 && other_failures == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

//--- snowball.f
+incdir+.
cache_pkg.sv
bus_pkg.sv
req_fifo.sv
cache_lookup.sv
mem_sequencer.sv
snowball_top.sv
snowball_tb.sv

//--- Bender.yml
package:
  name: snowball

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cache_pkg.sv
      - bus_pkg.sv
      - req_fifo.sv
      - cache_lookup.sv
      - mem_sequencer.sv
      - snowball_top.sv
  - target: test
    files:
      - snowball_tb.sv

//--- snowball_stimulus.txt
# Columns op addr data vmem force exp_data exp_fault in hex
# Ops 0 table write / 1 write / 2 read hit / 3 bus read / 4 faulting read / 5 memory check / 6 hold
3 00001010 00001010 0 0 ffffefef 0
2 00001010 00000000 0 0 ffffefef 0
1 00002020 cafe0001 0 0 00000000 0
2 00002020 00000000 0 0 cafe0001 0
5 00002020 00000000 0 0 cafe0001 0
3 00002020 00002020 0 1 cafe0001 0
6 00000001 00000000 0 0 00000000 0
1 00003000 a0a03000 0 0 00000000 0
1 00003004 a0a03004 0 0 00000000 0
1 00003008 a0a03008 0 0 00000000 0
1 0000300c a0a0300c 0 0 00000000 0
1 00003010 a0a03010 0 0 00000000 0
1 00003014 a0a03014 0 0 00000001 0
3 00003040 00003040 0 0 ffffcfbf 0
0 12345600 0abc1234 0 0 00000000 0
3 12345678 0abc5678 1 0 f543a987 0
1 12345680 600df00d 1 0 00000000 0
5 0abc5680 00000000 0 0 600df00d 0
4 43215610 00000000 1 0 f543a987 1
3 c0000040 c0000040 0 0 c0000041 0
